// File: filelist.f
+incdir+hdl
+incdir+sim
hdl/rs_pkg.sv
hdl/slot_dispatch_if.sv
hdl/slot_result_if.sv
hdl/rs_alloc.sv
hdl/rs_slot.sv
hdl/rs_select.sv
hdl/rs_top.sv
sim/tb_rs.sv

// File: hdl/rs_alloc.sv
/*
 * Dispatch allocator
 * Resolves both source operands against the register value, the
 * ready flag and same-cycle wakeups, and grants the lowest free entry.
 */
`include "rs_consts.svh"

module rs_alloc (
    input  logic             dispatch_valid,
    input  rs_pkg::alu_op_t  dispatch_op,
    input  rs_pkg::tag_t     src_tag_0,
    input  rs_pkg::tag_t     src_tag_1,
    input  rs_pkg::data_t    src_value_0,
    input  rs_pkg::data_t    src_value_1,
    input  logic             src_ready_0,
    input  logic             src_ready_1,
    input  rs_pkg::tag_t     dest_tag,
    input  logic             wake_valid,
    input  rs_pkg::tag_t     wake_tag,
    input  rs_pkg::data_t    wake_value,
    output logic             full,
    slot_dispatch_if.alloc   dsp,
    slot_result_if.select    res
);
    import rs_pkg::*;

    logic [`RS_SLOTS-1:0] free_vec;
    tag_t                 in_tag [2];
    data_t                in_value [2];
    logic                 in_ready [2];

    assign in_tag[0]   = src_tag_0;
    assign in_tag[1]   = src_tag_1;
    assign in_value[0] = src_value_0;
    assign in_value[1] = src_value_1;
    assign in_ready[0] = src_ready_0;
    assign in_ready[1] = src_ready_1;

    //////////////////////////////
    // free entries and grant
    //////////////////////////////
    always_comb begin
        for (int s = 0; s < `RS_SLOTS; s++) begin
            free_vec[s] = ~dsp.busy[s];
        end
    end

    assign full = ~|free_vec;

    // isolate lowest free bit
    assign dsp.grant = (dispatch_valid && !full) ? (free_vec & (~free_vec + 1'b1)) : '0;

    //////////////////////////////
    // source resolution
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dsp.src_tag[i] = in_tag[i];
            if (in_tag[i] == `ZERO_TAG || in_ready[i]) begin
                dsp.src_value[i] = in_value[i];
                dsp.src_ready[i] = 1'b1;
            end else if (wake_valid && wake_tag == in_tag[i]) begin
                dsp.src_value[i] = wake_value;
                dsp.src_ready[i] = 1'b1;
            end else if (res.bc_valid && res.bc_tag == in_tag[i]) begin
                // producer finishing in this very cycle
                dsp.src_value[i] = res.bc_value;
                dsp.src_ready[i] = 1'b1;
            end else begin
                dsp.src_value[i] = in_value[i];
                dsp.src_ready[i] = 1'b0;
            end
        end
    end

    assign dsp.op       = dispatch_op;
    assign dsp.dest_tag = dest_tag;

    always_comb begin
        assert ($onehot0(dsp.grant) && (dsp.grant & ~free_vec) == '0)
            else $error("rs_alloc: grant not one-hot or targets a busy entry");
    end

endmodule

// File: hdl/rs_consts.svh
/*
 * Reservation station constants
 * Entry count, operand width and tag encoding shared by the
 * package, the interfaces and the RTL modules.
 */
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// number of entries
`define RS_SLOTS 8

// operand and result width
`define XLEN 32

// tag width, tag 0 means the value comes straight from the register file
`define TAG_W 5
`define ZERO_TAG 5'd0

`endif

// File: hdl/rs_pkg.sv
/*
 * Reservation station package
 * Operand, tag, opcode and entry state types used by the
 * allocator, the entries and the result selector.
 */
package rs_pkg;

    `include "rs_consts.svh"

    typedef logic [`XLEN-1:0]  data_t;
    typedef logic [`TAG_W-1:0] tag_t;

    // integer ALU opcodes, shifts use the low 5 bits of operand b
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_WAIT = 2'd1,
        ST_DONE = 2'd2
    } slot_state_t;

endpackage

// File: hdl/rs_select.sv
/*
 * Result selector
 * Round-robin pick of one finished entry per cycle, acknowledged
 * and registered onto the result broadcast.
 */
`include "rs_consts.svh"

module rs_select (
    input  logic          clock,
    input  logic          reset,
    input  logic          squash,
    slot_result_if.select res
);
    import rs_pkg::*;

    localparam int IDX_W = $clog2(`RS_SLOTS);

    logic [IDX_W-1:0] last_ptr;
    logic [IDX_W-1:0] pick_idx;
    logic [IDX_W-1:0] probe;
    logic             found;
    tag_t             sel_tag;
    data_t            sel_value;

    // search starts just after the last entry taken
    always_comb begin
        found    = 1'b0;
        pick_idx = last_ptr;
        for (int k = 1; k <= `RS_SLOTS; k++) begin
            probe = IDX_W'((int'(last_ptr) + k) % `RS_SLOTS);
            if (!found && res.done[probe]) begin
                found    = 1'b1;
                pick_idx = probe;
            end
        end
    end

    assign res.ack   = (found && !reset && !squash) ? (`RS_SLOTS'(1) << pick_idx) : '0;
    assign sel_tag   = res.res_tag[pick_idx];
    assign sel_value = res.res_value[pick_idx];

    //////////////////////////////
    // result broadcast
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            res.bc_valid <= 1'b0;
            last_ptr     <= '0;
        end else begin
            res.bc_valid <= |res.ack;
            if (|res.ack) begin
                last_ptr <= pick_idx;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (|res.ack) begin
            res.bc_tag   <= sel_tag;
            res.bc_value <= sel_value;
        end
    end

    // an acked entry has left done by the next cycle
    assert property (@(posedge clock) disable iff (reset)
        |res.ack |=> (res.ack & $past(res.ack)) == '0)
        else $error("rs_select: same entry acked in two consecutive cycles");

endmodule

// File: hdl/rs_slot.sv
/*
 * Reservation entry
 * Holds one operation with its two operands, snoops the external
 * wakeup and the internal broadcast, executes once both operands
 * are present and holds the result until the selector takes it.
 */
`include "rs_consts.svh"

module rs_slot #(
    parameter int SLOT_IDX = 0
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           squash,
    input  logic           wake_valid,
    input  rs_pkg::tag_t   wake_tag,
    input  rs_pkg::data_t  wake_value,
    slot_dispatch_if.slot  dsp,
    slot_result_if.slot    res
);
    import rs_pkg::*;

    typedef struct packed {
        tag_t  tag;
        data_t value;
        logic  ready;
    } operand_t;

    slot_state_t state;
    alu_op_t     op_q;
    tag_t        dest_q;
    operand_t    opnd [2];
    data_t       result_q;
    data_t       alu_out;
    data_t       op_a;
    data_t       op_b;
    logic        both_ready;

    assign op_a       = opnd[0].value;
    assign op_b       = opnd[1].value;
    assign both_ready = opnd[0].ready && opnd[1].ready;

    //////////////////////////////
    // ALU
    //////////////////////////////
    always_comb begin
        case (op_q)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLL: alu_out = op_a << op_b[4:0];
            ALU_SRL: alu_out = op_a >> op_b[4:0];
            ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_out = '0;
        endcase
    end

    //////////////////////////////
    // entry state
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (dsp.grant[SLOT_IDX]) state <= ST_WAIT;
                ST_WAIT: if (both_ready) state <= ST_DONE;
                ST_DONE: if (res.ack[SLOT_IDX]) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload, operand capture and execute
    always_ff @(posedge clock) begin
        if (state == ST_IDLE && dsp.grant[SLOT_IDX]) begin
            op_q   <= alu_op_t'(dsp.op);
            dest_q <= dsp.dest_tag;
            for (int i = 0; i < 2; i++) begin
                opnd[i] <= '{dsp.src_tag[i], dsp.src_value[i], dsp.src_ready[i]};
            end
        end else if (state == ST_WAIT) begin
            for (int i = 0; i < 2; i++) begin
                if (!opnd[i].ready) begin
                    if (wake_valid && wake_tag == opnd[i].tag) begin
                        opnd[i].value <= wake_value;
                        opnd[i].ready <= 1'b1;
                    end else if (res.bc_valid && res.bc_tag == opnd[i].tag) begin
                        opnd[i].value <= res.bc_value;
                        opnd[i].ready <= 1'b1;
                    end
                end
            end
            if (both_ready) begin
                result_q <= alu_out;
            end
        end
    end

    assign dsp.busy[SLOT_IDX]      = (state != ST_IDLE);
    assign res.done[SLOT_IDX]      = (state == ST_DONE);
    assign res.res_tag[SLOT_IDX]   = dest_q;
    assign res.res_value[SLOT_IDX] = result_q;

    // selector only takes finished entries
    assert property (@(posedge clock) disable iff (reset)
        res.ack[SLOT_IDX] |-> state == ST_DONE)
        else $error("rs_slot %0d: ack while not done", SLOT_IDX);

endmodule

// File: hdl/rs_top.sv
/*
 * Integer ALU reservation station, top level
 * Allocator, entry array and result selector joined by the
 * dispatch and result interfaces.
 */
`include "rs_consts.svh"

module rs_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             squash,
    input  logic             dispatch_valid,
    input  rs_pkg::alu_op_t  dispatch_op,
    input  rs_pkg::tag_t     src_tag_0,
    input  rs_pkg::tag_t     src_tag_1,
    input  rs_pkg::data_t    src_value_0,
    input  rs_pkg::data_t    src_value_1,
    input  logic             src_ready_0,
    input  logic             src_ready_1,
    input  rs_pkg::tag_t     dest_tag,
    input  logic             wake_valid,
    input  rs_pkg::tag_t     wake_tag,
    input  rs_pkg::data_t    wake_value,
    output logic             full,
    output logic             result_valid,
    output rs_pkg::tag_t     result_tag,
    output rs_pkg::data_t    result_value
);

    slot_dispatch_if dsp_if ();
    slot_result_if   res_if ();

    rs_alloc i_alloc (
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .src_tag_0      (src_tag_0),
        .src_tag_1      (src_tag_1),
        .src_value_0    (src_value_0),
        .src_value_1    (src_value_1),
        .src_ready_0    (src_ready_0),
        .src_ready_1    (src_ready_1),
        .dest_tag       (dest_tag),
        .wake_valid     (wake_valid),
        .wake_tag       (wake_tag),
        .wake_value     (wake_value),
        .full           (full),
        .dsp            (dsp_if.alloc),
        .res            (res_if.select)
    );

    // entry array
    for (genvar g = 0; g < `RS_SLOTS; g++) begin : g_slot
        rs_slot #(
            .SLOT_IDX (g)
        ) i_slot (
            .clock      (clock),
            .reset      (reset),
            .squash     (squash),
            .wake_valid (wake_valid),
            .wake_tag   (wake_tag),
            .wake_value (wake_value),
            .dsp        (dsp_if.slot),
            .res        (res_if.slot)
        );
    end

    rs_select i_select (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .res    (res_if.select)
    );

    assign result_valid = res_if.bc_valid;
    assign result_tag   = res_if.bc_tag;
    assign result_value = res_if.bc_value;

endmodule

// File: hdl/slot_dispatch_if.sv
/*
 * Dispatch interface
 * Carries the resolved dispatch payload and one-hot grant from the
 * allocator to the entries, and the busy flags back.
 */
`include "rs_consts.svh"

interface slot_dispatch_if;

    logic [`RS_SLOTS-1:0] grant;
    logic [2:0]           op;
    logic [`TAG_W-1:0]    src_tag [2];
    logic [`XLEN-1:0]     src_value [2];
    logic [1:0]           src_ready;
    logic [`TAG_W-1:0]    dest_tag;

    // one element per entry
    logic                 busy [`RS_SLOTS];

    modport alloc (
        output grant, op, src_tag, src_value, src_ready, dest_tag,
        input  busy
    );

    modport slot (
        input  grant, op, src_tag, src_value, src_ready, dest_tag,
        output busy
    );

endinterface

// File: hdl/slot_result_if.sv
/*
 * Result interface
 * Entry completion flags and results toward the selector, the
 * acknowledge back, and the internal result broadcast.
 */
`include "rs_consts.svh"

interface slot_result_if;

    logic                 done [`RS_SLOTS];
    logic [`XLEN-1:0]     res_value [`RS_SLOTS];
    logic [`TAG_W-1:0]    res_tag [`RS_SLOTS];
    logic [`RS_SLOTS-1:0] ack;

    // broadcast, also the top level result bus
    logic                 bc_valid;
    logic [`TAG_W-1:0]    bc_tag;
    logic [`XLEN-1:0]     bc_value;

    modport slot (
        output done, res_value, res_tag,
        input  ack, bc_valid, bc_tag, bc_value
    );

    modport select (
        input  done, res_value, res_tag,
        output ack, bc_valid, bc_tag, bc_value
    );

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_rs -Mdir obj_dir -o tb_rs_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rs_sim | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// File: sim/tb_rs_model.svh
/*
 * Reservation station reference model
 * Tracks each accepted operation by its dest tag, fills in source
 * values from wakeups and results, and gives the expected result.
 */
`ifndef TB_RS_MODEL_SVH
`define TB_RS_MODEL_SVH

localparam int NTAGS = 1 << `TAG_W;

logic    pend [NTAGS];
logic    dead [NTAGS];
alu_op_t m_op [NTAGS];
tag_t    m_tag [NTAGS][2];
data_t   m_val [NTAGS][2];
logic    m_known [NTAGS][2];
int      pend_count;

// opcode rules, slt decided from the sign bits first
function automatic data_t expect_value(alu_op_t op, data_t a, data_t b);
    case (op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_AND: return a & b;
        ALU_OR:  return a | b;
        ALU_XOR: return a ^ b;
        ALU_SLL: return a << b[4:0];
        ALU_SRL: return a >> b[4:0];
        default: begin
            if (a[`XLEN-1] != b[`XLEN-1]) begin
                return data_t'(a[`XLEN-1]);
            end
            return data_t'(a < b);
        end
    endcase
endfunction

function automatic void model_reset();
    for (int t = 0; t < NTAGS; t++) begin
        pend[t] = 1'b0;
        dead[t] = 1'b0;
    end
    pend_count = 0;
endfunction

function automatic void model_add(alu_op_t op, tag_t dest, tag_t t0, data_t v0, logic r0,
                                  tag_t t1, data_t v1, logic r1);
    pend[dest]       = 1'b1;
    m_op[dest]       = op;
    m_tag[dest][0]   = t0;
    m_val[dest][0]   = v0;
    m_known[dest][0] = r0 || t0 == `ZERO_TAG;
    m_tag[dest][1]   = t1;
    m_val[dest][1]   = v1;
    m_known[dest][1] = r1 || t1 == `ZERO_TAG;
    pend_count++;
endfunction

// a tag's value becomes known to every waiting source
function automatic void model_snoop(tag_t t, data_t v);
    for (int d = 0; d < NTAGS; d++) begin
        for (int i = 0; i < 2; i++) begin
            if (pend[d] && !m_known[d][i] && m_tag[d][i] == t) begin
                m_val[d][i]   = v;
                m_known[d][i] = 1'b1;
            end
        end
    end
endfunction

function automatic void model_retire(tag_t d);
    pend[d] = 1'b0;
    pend_count--;
endfunction

function automatic void model_squash();
    for (int t = 0; t < NTAGS; t++) begin
        if (pend[t]) begin
            dead[t] = 1'b1;
            pend[t] = 1'b0;
        end
    end
    pend_count = 0;
endfunction

function automatic logic model_ready(tag_t d);
    return m_known[d][0] && m_known[d][1];
endfunction

`endif

// File: sim/tb_rs.sv
/*
 * Reservation station testbench
 * Random dispatches, external wakeups, chains and squash driven
 * into the station and checked against a reference model.
 */
`include "rs_consts.svh"

module tb_rs;
    import rs_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    // dest tags 1..23 and external wake tags 24..31
    localparam int DEST_TAGS       = 23;
    localparam int EXT_BASE        = 24;

    logic    clock;
    logic    reset;
    logic    squash;
    logic    dispatch_valid;
    alu_op_t dispatch_op;
    tag_t    src_tag_0;
    tag_t    src_tag_1;
    data_t   src_value_0;
    data_t   src_value_1;
    logic    src_ready_0;
    logic    src_ready_1;
    tag_t    dest_tag;
    logic    wake_valid;
    tag_t    wake_tag;
    data_t   wake_value;
    logic    full;
    logic    result_valid;
    tag_t    result_tag;
    data_t   result_value;

    // stimulus for the coming falling edge
    logic    s_valid;
    logic    s_r0;
    logic    s_r1;
    logic    s_wake;
    logic    s_squash;
    alu_op_t s_op;
    tag_t    s_t0;
    tag_t    s_t1;
    tag_t    s_dest;
    tag_t    s_wtag;
    data_t   s_v0;
    data_t   s_v1;
    data_t   s_wval;

    // result bus as seen at the last falling edge
    logic    bus_valid;
    tag_t    bus_tag;
    data_t   bus_value;

    logic [31:0] rand_state;
    int          err_count;
    int          err_mark;
    int          tests_failed;
    int          dest_cursor;

    `include "tb_rs_model.svh"

    rs_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((NUM_TESTS * CYCLES_PER_TEST + 8) * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("Test failed");
        $finish;
    end

    //////////////////////////////
    // random helpers
    //////////////////////////////
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rand_state = x;
        return x;
    endfunction

    function automatic tag_t ext_tag();
        logic [31:0] r;
        r = next_rand();
        return tag_t'(EXT_BASE + int'(r[2:0]));
    endfunction

    function automatic tag_t free_dest();
        for (int k = 0; k < DEST_TAGS; k++) begin
            dest_cursor = dest_cursor % DEST_TAGS + 1;
            if (!pend[tag_t'(dest_cursor)] && !dead[tag_t'(dest_cursor)]) begin
                return tag_t'(dest_cursor);
            end
        end
        return tag_t'(1);
    endfunction

    // an uncompleted dest tag or the zero tag if none
    function automatic tag_t pick_producer();
        logic [31:0] r;
        int          t;
        r = next_rand();
        for (int k = 0; k < NTAGS; k++) begin
            t = (int'(r[4:0]) + k) % NTAGS;
            if (pend[t]) begin
                return tag_t'(t);
            end
        end
        return `ZERO_TAG;
    endfunction

    task automatic set_dispatch(input tag_t t0, input logic r0, input tag_t t1, input logic r1);
        logic [31:0] r;
        r      = next_rand();
        s_valid = 1'b1;
        s_op    = alu_op_t'(r[2:0]);
        s_dest  = free_dest();
        s_t0    = t0;
        s_r0    = r0;
        s_v0    = next_rand();
        s_t1    = t1;
        s_r1    = r1;
        s_v1    = next_rand();
    endtask

    task automatic set_wake(input tag_t t);
        s_wake = 1'b1;
        s_wtag = t;
        s_wval = next_rand();
    endtask

    task automatic clear_stimulus();
        s_valid  = 1'b0;
        s_squash = 1'b0;
        s_wake   = 1'b0;
        s_op     = ALU_ADD;
        s_t0     = `ZERO_TAG;
        s_t1     = `ZERO_TAG;
        s_dest   = `ZERO_TAG;
        s_wtag   = `ZERO_TAG;
        s_r0     = 1'b0;
        s_r1     = 1'b0;
        s_v0     = '0;
        s_v1     = '0;
        s_wval   = '0;
    endtask

    //////////////////////////////
    // per-cycle check and drive
    //////////////////////////////
    task automatic next_cycle();
        @(negedge clock);
        bus_valid = (result_valid === 1'b1);
        bus_tag   = result_tag;
        bus_value = result_value;
        if ($isunknown({full, result_valid})) begin
            $display("full or result_valid is unknown at time %0t", $time);
            err_count++;
        end
        if (bus_valid) begin
            if (dead[bus_tag]) begin
                $display("ERR %0t: squashed tag %0d on the result bus", $time, bus_tag);
                err_count++;
            end else if (!pend[bus_tag]) begin
                $display("ERR %0t: unexpected tag %0d on the result bus", $time, bus_tag);
                err_count++;
            end else if (!model_ready(bus_tag)) begin
                $display("ERR %0t: tag %0d issued before its operands", $time, bus_tag);
                err_count++;
            end else if (bus_value !== expect_value(m_op[bus_tag], m_val[bus_tag][0],
                                                    m_val[bus_tag][1])) begin
                $display("ERR %0t: tag %0d result %h, expected %h", $time, bus_tag, bus_value,
                         expect_value(m_op[bus_tag], m_val[bus_tag][0], m_val[bus_tag][1]));
                err_count++;
            end
            if (pend[bus_tag]) begin
                model_retire(bus_tag);
            end
        end
        // freed entries leave at the same edge their result shows up
        if (full !== (pend_count == `RS_SLOTS)) begin
            $display("ERR %0t: full is %b with %0d entries in use", $time, full, pend_count);
            err_count++;
        end
    endtask

    task automatic drive();
        logic accepted;
        accepted       = s_valid && !full && !s_squash;
        squash         = s_squash;
        dispatch_valid = s_valid;
        dispatch_op    = s_op;
        src_tag_0      = s_t0;
        src_tag_1      = s_t1;
        src_value_0    = s_v0;
        src_value_1    = s_v1;
        src_ready_0    = s_r0;
        src_ready_1    = s_r1;
        dest_tag       = s_dest;
        wake_valid     = s_wake;
        wake_tag       = s_wtag;
        wake_value     = s_wval;
        if (s_squash) begin
            model_squash();
        end else begin
            if (accepted) begin
                model_add(s_op, s_dest, s_t0, s_v0, s_r0, s_t1, s_v1, s_r1);
            end
            // wake goes ahead of the broadcast as in the station
            if (s_wake) begin
                model_snoop(s_wtag, s_wval);
            end
            if (bus_valid) begin
                model_snoop(bus_tag, bus_value);
            end
        end
        clear_stimulus();
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while (pend_count > 0 && n < limit) begin
            next_cycle();
            set_wake(tag_t'(EXT_BASE + n % 8));
            drive();
            n++;
        end
        if (pend_count > 0) begin
            $display("%0d operations never produced a result", pend_count);
            err_count++;
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////
    task automatic run_reset_idle();
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            if (full !== 1'b0 || result_valid !== 1'b0) begin
                $display("ERR %0t: full=%b result_valid=%b while idle", $time, full,
                         result_valid);
                err_count++;
            end
            drive();
        end
    endtask

    task automatic run_independent();
        logic [31:0] r;
        for (int i = 0; i < 60; i++) begin
            next_cycle();
            r = next_rand();
            if (r[1:0] != 2'b00) begin
                set_dispatch(r[2] ? ext_tag() : `ZERO_TAG, 1'b1,
                             r[3] ? ext_tag() : `ZERO_TAG, r[3]);
            end
            drive();
        end
        drain(100);
    endtask

    task automatic run_external();
        logic [31:0] r;
        for (int i = 0; i < 40; i++) begin
            next_cycle();
            r = next_rand();
            if (r[0]) begin
                set_dispatch(ext_tag(), 1'b0, `ZERO_TAG, 1'b0);
                // wake arriving with the dispatch itself
                if (r[2:1] == 2'b00) begin
                    set_wake(s_t0);
                end
            end
            if (!s_wake && r[4:3] == 2'b00) begin
                set_wake(ext_tag());
            end
            drive();
        end
        drain(100);
    endtask

    task automatic run_chained();
        logic [31:0] r;
        tag_t        producer;
        for (int i = 0; i < 50; i++) begin
            next_cycle();
            r        = next_rand();
            producer = pick_producer();
            if (r[1:0] != 2'b00) begin
                set_dispatch((r[2] && producer != `ZERO_TAG) ? producer : `ZERO_TAG, 1'b0,
                             (r[4:3] == 2'b00) ? ext_tag() : `ZERO_TAG, 1'b0);
            end
            if (r[6:5] == 2'b00) begin
                set_wake(ext_tag());
            end
            drive();
        end
        drain(100);
    endtask

    task automatic run_full();
        for (int i = 0; i < `RS_SLOTS; i++) begin
            next_cycle();
            set_dispatch(tag_t'(EXT_BASE + i), 1'b0, `ZERO_TAG, 1'b0);
            drive();
        end
        next_cycle();
        if (full !== 1'b1) begin
            $display("ERR %0t: full is %b with all %0d entries taken", $time, full,
                     `RS_SLOTS);
            err_count++;
        end
        // refused dispatch that the model never records
        set_dispatch(`ZERO_TAG, 1'b1, `ZERO_TAG, 1'b1);
        drive();
        for (int i = 0; i < 5; i++) begin
            next_cycle();
            drive();
        end
        drain(100);
        next_cycle();
        if (full !== 1'b0) begin
            $display("ERR %0t: full is %b after all entries drained", $time, full);
            err_count++;
        end
        drive();
    endtask

    task automatic run_squash();
        logic [31:0] r;
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            if (i % 2 == 0) begin
                set_dispatch(tag_t'(EXT_BASE + i), 1'b0, `ZERO_TAG, 1'b0);
            end else begin
                set_dispatch(`ZERO_TAG, 1'b1, `ZERO_TAG, 1'b1);
            end
            drive();
        end
        next_cycle();
        s_squash = 1'b1;
        drive();
        next_cycle();
        if (result_valid !== 1'b0 || full !== 1'b0) begin
            $display("ERR %0t: result_valid=%b full=%b after squash", $time, result_valid,
                     full);
            err_count++;
        end
        drive();
        // wake the old sources and expect nothing back
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            set_wake(tag_t'(EXT_BASE + i));
            drive();
        end
        for (int i = 0; i < 12; i++) begin
            next_cycle();
            r = next_rand();
            if (r[0]) begin
                set_dispatch(`ZERO_TAG, 1'b1, r[1] ? ext_tag() : `ZERO_TAG, 1'b0);
            end
            drive();
        end
        drain(100);
    endtask

    task automatic end_test(input int idx, input string name);
        if (err_count == err_mark) begin
            $display("[%0d] %s: ok", idx, name);
        end else begin
            $display("[%0d] %s: FAIL, %0d errors", idx, name, err_count - err_mark);
            tests_failed++;
        end
        err_mark = err_count;
    endtask

    initial begin
        rand_state   = 32'h273b0214;
        err_count    = 0;
        err_mark     = 0;
        tests_failed = 0;
        dest_cursor  = 0;
        bus_valid    = 1'b0;
        bus_tag      = `ZERO_TAG;
        bus_value    = '0;
        model_reset();
        clear_stimulus();
        reset = 1'b1;
        drive();
        repeat (8) @(negedge clock);
        reset = 1'b0;

        run_reset_idle();
        end_test(1, "reset idle");
        run_independent();
        end_test(2, "independent ops");
        run_external();
        end_test(3, "external wakeup");
        run_chained();
        end_test(4, "chained ops");
        run_full();
        end_test(5, "full and stall");
        run_squash();
        end_test(6, "squash");

        $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
